//--- hdl/soc_bus_pkg.sv
/*
 * System bus package.
 * Wishbone request and response structs, the peripheral regions,
 * the arbiter states and the sizes of the console address map.
 */

package soc_bus_pkg;

    // ----------------------------------------------------------
    // Sizes and address map
    // ----------------------------------------------------------

    // Byte address. Bit 19 is flash and bits 18:16 pick the region.
    localparam int addr_width = 20;
    localparam int data_width = 32;
    localparam int sel_width = 4;

    // The RAM is word addressed through address bits 9:2.
    localparam int ram_words = 256;
    localparam int ram_index_bits = $clog2(ram_words);

    localparam int pad_buttons = 12;
    localparam int led_width = 8;

    // Register offsets inside the status block.
    localparam logic [3:0] status_frame_off = 4'h0;
    localparam logic [3:0] status_led_off = 4'h4;

    // ----------------------------------------------------------
    // Bus types
    // ----------------------------------------------------------

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [addr_width-1:0] adr;
        logic [data_width-1:0] dat_w;
        logic [sel_width-1:0] sel;
    } bus_req_t;

    typedef struct packed {
        logic [data_width-1:0] dat_r;
        logic ack;
        logic err;
    } bus_rsp_t;

    // Codes follow the region field of the address where one exists.
    typedef enum logic [2:0] {
        region_ram = 3'd0,
        region_status = 3'd2,
        region_pad = 3'd4,
        region_none = 3'd7
    } region_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_cpu,
        arb_dma
    } arb_state_e;

endpackage

//--- hdl/bus_arbiter.sv
/*
 * Round-robin arbiter for two Wishbone classic masters.
 * Registers the winning request onto the shared bus and returns
 * the shared response to the granted master only.
 */

`timescale 1ns/10ps

module bus_arbiter (
    input logic clk,
    input logic reset,

    input soc_bus_pkg::bus_req_t cpu_req,
    input soc_bus_pkg::bus_req_t dma_req,
    output soc_bus_pkg::bus_rsp_t cpu_rsp,
    output soc_bus_pkg::bus_rsp_t dma_rsp,

    output soc_bus_pkg::bus_req_t bus_req,
    input soc_bus_pkg::bus_rsp_t bus_rsp
);
    soc_bus_pkg::arb_state_e state;
    logic last_cpu;
    logic cpu_want;
    logic dma_want;
    logic pick_cpu;
    logic pick_dma;
    logic done;

    assign cpu_want = cpu_req.cyc && cpu_req.stb;
    assign dma_want = dma_req.cyc && dma_req.stb;

    // On a tie the master that was not served last goes first.
    assign pick_cpu = cpu_want && (!dma_want || !last_cpu);
    assign pick_dma = dma_want && !pick_cpu;

    assign done = bus_rsp.ack || bus_rsp.err;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= soc_bus_pkg::arb_idle;
            last_cpu <= 1'b0;
            bus_req.cyc <= 1'b0;
            bus_req.stb <= 1'b0;
        end else begin
            case (state)
                soc_bus_pkg::arb_idle: begin
                    if (pick_cpu) begin
                        state <= soc_bus_pkg::arb_cpu;
                        last_cpu <= 1'b1;
                        bus_req <= cpu_req;
                    end else if (pick_dma) begin
                        state <= soc_bus_pkg::arb_dma;
                        last_cpu <= 1'b0;
                        bus_req <= dma_req;
                    end
                end
                default: begin
                    // Hold the grant until the slave ends the cycle.
                    if (done) begin
                        state <= soc_bus_pkg::arb_idle;
                        bus_req.cyc <= 1'b0;
                        bus_req.stb <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_comb begin
        cpu_rsp = bus_rsp;
        dma_rsp = bus_rsp;
        cpu_rsp.ack = bus_rsp.ack && (state == soc_bus_pkg::arb_cpu);
        cpu_rsp.err = bus_rsp.err && (state == soc_bus_pkg::arb_cpu);
        dma_rsp.ack = bus_rsp.ack && (state == soc_bus_pkg::arb_dma);
        dma_rsp.err = bus_rsp.err && (state == soc_bus_pkg::arb_dma);
    end

endmodule

//--- hdl/address_decoder.sv
/*
 * Address decoder for the console bus.
 * Maps the granted address onto one peripheral select and answers
 * accesses outside the map with a Wishbone error.
 */

`timescale 1ns/10ps

module address_decoder (
    input logic clk,
    input logic reset,

    input soc_bus_pkg::bus_req_t bus_req,

    output logic ram_sel,
    output logic status_sel,
    output logic pad_sel,
    output soc_bus_pkg::region_e region,
    output logic dec_err
);
    logic active;

    assign active = bus_req.cyc && bus_req.stb;

    // Flash, video and audio are not part of this system, so their
    // regions fall through to region_none along with 5 to 7.
    always_comb begin
        if (bus_req.adr[soc_bus_pkg::addr_width-1]) begin
            region = soc_bus_pkg::region_none;
        end else begin
            case (bus_req.adr[soc_bus_pkg::addr_width-2 -: 3])
                3'd0: region = soc_bus_pkg::region_ram;
                3'd2: region = soc_bus_pkg::region_status;
                3'd4: region = soc_bus_pkg::region_pad;
                default: region = soc_bus_pkg::region_none;
            endcase
        end
    end

    always_comb begin
        ram_sel = active && (region == soc_bus_pkg::region_ram);
        status_sel = active && (region == soc_bus_pkg::region_status);
        pad_sel = active && (region == soc_bus_pkg::region_pad);
    end

    // ----------------------------------------------------------
    // Error response
    // ----------------------------------------------------------

    // One pulse per unmapped request; it drops with the request.
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_err <= 1'b0;
        end else begin
            dec_err <= active && (region == soc_bus_pkg::region_none) && !dec_err;
        end
    end

endmodule

//--- hdl/cpu_ram.sv
/*
 * Work RAM, one 32-bit word per entry.
 * Byte write enables come from the bus select lines, and read data
 * and acknowledge are registered.
 */

`timescale 1ns/10ps

module cpu_ram (
    input logic clk,
    input logic reset,

    input soc_bus_pkg::bus_req_t bus_req,
    input logic sel,
    output soc_bus_pkg::bus_rsp_t rsp
);
    logic [soc_bus_pkg::data_width-1:0] mem [soc_bus_pkg::ram_words];
    logic [soc_bus_pkg::ram_index_bits-1:0] index;
    logic [soc_bus_pkg::data_width-1:0] dat_q;
    logic ack_q;
    logic access;

    assign index = bus_req.adr[soc_bus_pkg::ram_index_bits+1:2];

    // The ack blocks a second access while the master still holds it.
    assign access = sel && bus_req.cyc && bus_req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (access && bus_req.we) begin
            for (int b = 0; b < soc_bus_pkg::sel_width; b++) begin
                if (bus_req.sel[b]) begin
                    mem[index][8*b +: 8] <= bus_req.dat_w[8*b +: 8];
                end
            end
        end
        dat_q <= mem[index];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign rsp = '{dat_r: dat_q, ack: ack_q, err: 1'b0};

endmodule

//--- hdl/status_regs.sv
/*
 * Status register block.
 * Holds the frame counter, advanced by frame_tick, and the LED
 * register that drives the board LEDs.
 */

`timescale 1ns/10ps

module status_regs (
    input logic clk,
    input logic reset,

    input soc_bus_pkg::bus_req_t bus_req,
    input logic sel,
    input logic frame_tick,
    output soc_bus_pkg::bus_rsp_t rsp,
    output logic [soc_bus_pkg::led_width-1:0] leds
);
    logic [soc_bus_pkg::data_width-1:0] frame_count;
    logic [soc_bus_pkg::led_width-1:0] led_reg;
    logic [soc_bus_pkg::data_width-1:0] dat_q;
    logic ack_q;
    logic access;
    logic [3:0] offset;

    assign offset = bus_req.adr[3:0];
    assign access = sel && bus_req.cyc && bus_req.stb && !ack_q;

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_count <= '0;
            led_reg <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (frame_tick) begin
                frame_count <= frame_count + 1'b1;
            end
            // The frame counter ignores writes.
            if (access && bus_req.we && offset == soc_bus_pkg::status_led_off) begin
                led_reg <= bus_req.dat_w[soc_bus_pkg::led_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        case (offset)
            soc_bus_pkg::status_frame_off: dat_q <= frame_count;
            soc_bus_pkg::status_led_off: begin
                dat_q <= {{(soc_bus_pkg::data_width-soc_bus_pkg::led_width){1'b0}}, led_reg};
            end
            default: dat_q <= '0;
        endcase
    end

    assign rsp = '{dat_r: dat_q, ack: ack_q, err: 1'b0};
    assign leds = led_reg;

endmodule

//--- hdl/pad_port.sv
/*
 * Gamepad port.
 * Brings the button lines into the clock domain through two flops
 * and returns them zero-extended on a read.
 */

`timescale 1ns/10ps

module pad_port (
    input logic clk,
    input logic reset,

    input soc_bus_pkg::bus_req_t bus_req,
    input logic sel,
    input logic [soc_bus_pkg::pad_buttons-1:0] pad_buttons_in,
    output soc_bus_pkg::bus_rsp_t rsp
);
    logic [soc_bus_pkg::pad_buttons-1:0] pad_meta;
    logic [soc_bus_pkg::pad_buttons-1:0] pad_sync;
    logic [soc_bus_pkg::data_width-1:0] dat_q;
    logic ack_q;
    logic access;
    logic write_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            pad_meta <= '0;
            pad_sync <= '0;
        end else begin
            pad_meta <= pad_buttons_in;
            pad_sync <= pad_meta;
        end
    end

    assign access = sel && bus_req.cyc && bus_req.stb && !ack_q;

    // Latch-style pads would take their strobe from here.
    assign write_en = access && bus_req.we;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // A write returns no data.
    always_ff @(posedge clk) begin
        if (write_en) begin
            dat_q <= '0;
        end else begin
            dat_q <= {{(soc_bus_pkg::data_width-soc_bus_pkg::pad_buttons){1'b0}}, pad_sync};
        end
    end

    assign rsp = '{dat_r: dat_q, ack: ack_q, err: 1'b0};

endmodule

//--- hdl/soc_bus.sv
/*
 * Console system bus.
 * Two masters share one Wishbone bus through the arbiter; the
 * decoder selects RAM, status registers or the gamepad port.
 */

`timescale 1ns/10ps

module soc_bus (
    input logic clk,
    input logic reset,

    input soc_bus_pkg::bus_req_t cpu_req,
    input soc_bus_pkg::bus_req_t dma_req,
    output soc_bus_pkg::bus_rsp_t cpu_rsp,
    output soc_bus_pkg::bus_rsp_t dma_rsp,

    input logic frame_tick,
    input logic [soc_bus_pkg::pad_buttons-1:0] pad_buttons_in,
    output logic [soc_bus_pkg::led_width-1:0] leds
);
    soc_bus_pkg::bus_req_t bus_req;
    soc_bus_pkg::bus_rsp_t bus_rsp;
    soc_bus_pkg::bus_rsp_t ram_rsp;
    soc_bus_pkg::bus_rsp_t status_rsp;
    soc_bus_pkg::bus_rsp_t pad_rsp;
    soc_bus_pkg::region_e region;
    logic ram_sel;
    logic status_sel;
    logic pad_sel;
    logic dec_err;

    bus_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .cpu_req(cpu_req), .dma_req(dma_req),
        .cpu_rsp(cpu_rsp), .dma_rsp(dma_rsp),
        .bus_req(bus_req), .bus_rsp(bus_rsp)
    );

    address_decoder u_decoder (
        .clk(clk), .reset(reset), .bus_req(bus_req),
        .ram_sel(ram_sel), .status_sel(status_sel), .pad_sel(pad_sel),
        .region(region), .dec_err(dec_err)
    );

    cpu_ram u_ram (
        .clk(clk), .reset(reset), .bus_req(bus_req), .sel(ram_sel), .rsp(ram_rsp)
    );

    status_regs u_status (
        .clk(clk), .reset(reset), .bus_req(bus_req), .sel(status_sel),
        .frame_tick(frame_tick), .rsp(status_rsp), .leds(leds)
    );

    pad_port u_pad (
        .clk(clk), .reset(reset), .bus_req(bus_req), .sel(pad_sel),
        .pad_buttons_in(pad_buttons_in), .rsp(pad_rsp)
    );

    // The request stays on the bus through the ack, so the region
    // still points at the answering peripheral.
    always_comb begin
        case (region)
            soc_bus_pkg::region_ram: bus_rsp = ram_rsp;
            soc_bus_pkg::region_status: bus_rsp = status_rsp;
            soc_bus_pkg::region_pad: bus_rsp = pad_rsp;
            default: bus_rsp = '{dat_r: '0, ack: 1'b0, err: dec_err};
        endcase
    end

endmodule

//--- dv/soc_bus_asserts.sv
/*
 * Protocol assertions for the console bus.
 * Bound to the top level, they watch the shared response and
 * the responses returned to the two masters.
 */

`timescale 1ns/10ps

module soc_bus_asserts (
    input logic clk,
    input logic reset,
    input soc_bus_pkg::bus_req_t bus_req,
    input soc_bus_pkg::bus_rsp_t bus_rsp,
    input soc_bus_pkg::bus_rsp_t cpu_rsp,
    input soc_bus_pkg::bus_rsp_t dma_rsp
);
    int excl_fails = 0;
    int stray_ack_fails = 0;
    int dual_rsp_fails = 0;
    int reset_rsp_fails = 0;

    a_ack_err_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(bus_rsp.ack && bus_rsp.err))
    else begin
        excl_fails++;
        $error("ack and err are high in the same cycle");
    end

    // A slave answers only a request that was on the bus a cycle earlier.
    a_ack_after_request: assert property (@(posedge clk) disable iff (reset)
        bus_rsp.ack |-> $past(bus_req.cyc && bus_req.stb))
    else begin
        stray_ack_fails++;
        $error("ack without a preceding cyc and stb");
    end

    a_one_master_answered: assert property (@(posedge clk) disable iff (reset)
        !((cpu_rsp.ack || cpu_rsp.err) && (dma_rsp.ack || dma_rsp.err)))
    else begin
        dual_rsp_fails++;
        $error("cpu and dma are answered in the same cycle");
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !(bus_rsp.ack || bus_rsp.err))
    else begin
        reset_rsp_fails++;
        $error("ack or err in the first cycle after reset");
    end

endmodule

//--- dv/soc_bus_tb.sv
/*
 * Testbench for the console system bus.
 * Drives both masters through RAM, status, gamepad and unmapped
 * accesses and through contention, then prints a summary.
 */

`timescale 1ns/10ps

module soc_bus_tb;

    localparam int cycles_per_access = 12;
    localparam int access_count = 160;
    localparam int idle_cycles = 80;
    // Roughly twice the expected run length.
    localparam int watchdog_cycles = 2 * (access_count * cycles_per_access + idle_cycles);
    localparam logic [19:0] frame_addr = {16'h2000, soc_bus_pkg::status_frame_off};
    localparam logic [19:0] led_addr = {16'h2000, soc_bus_pkg::status_led_off};
    localparam logic [19:0] pad_addr = 20'h40000;

    logic clk;
    logic reset;
    soc_bus_pkg::bus_req_t cpu_req;
    soc_bus_pkg::bus_req_t dma_req;
    soc_bus_pkg::bus_rsp_t cpu_rsp;
    soc_bus_pkg::bus_rsp_t dma_rsp;
    logic frame_tick;
    logic [soc_bus_pkg::pad_buttons-1:0] pad_buttons_in;
    logic [soc_bus_pkg::led_width-1:0] leds;

    int seed = 98;
    int errors = 0;
    int tests = 0;
    int test_start_errors = 0;
    logic [31:0] shadow [soc_bus_pkg::ram_words];
    bit grant_log [$];

    soc_bus i_dut (
        .clk(clk), .reset(reset),
        .cpu_req(cpu_req), .dma_req(dma_req),
        .cpu_rsp(cpu_rsp), .dma_rsp(dma_rsp),
        .frame_tick(frame_tick), .pad_buttons_in(pad_buttons_in), .leds(leds)
    );

    bind soc_bus soc_bus_asserts i_asserts (
        .clk(clk), .reset(reset), .bus_req(bus_req), .bus_rsp(bus_rsp),
        .cpu_rsp(cpu_rsp), .dma_rsp(dma_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic [19:0] ram_addr(input logic [7:0] idx);
        return {10'h000, idx, 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] byte_sel);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (byte_sel[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // One Wishbone classic cycle; the request is held until ack or err.
    task automatic bus_access(input bit use_dma, input logic write, input logic [19:0] addr,
                              input logic [31:0] data, input logic [3:0] byte_sel,
                              output soc_bus_pkg::bus_rsp_t rsp);
        soc_bus_pkg::bus_req_t req;
        req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: addr, dat_w: data, sel: byte_sel};
        @(posedge clk);
        if (use_dma) begin
            dma_req <= req;
        end else begin
            cpu_req <= req;
        end
        do begin
            @(negedge clk);
            rsp = use_dma ? dma_rsp : cpu_rsp;
        end while (!(rsp.ack || rsp.err));
        grant_log.push_back(use_dma);
        @(posedge clk);
        if (use_dma) begin
            dma_req <= '0;
        end else begin
            cpu_req <= '0;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("error %s: expected 0x%08h, got 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_ack(input soc_bus_pkg::bus_rsp_t rsp, input logic [19:0] addr);
        assert (rsp.ack && !rsp.err) else begin
            errors++;
            $display("access to 0x%05h ended with an error instead of an acknowledge", addr);
        end
    endtask

    task automatic check_err(input soc_bus_pkg::bus_rsp_t rsp, input logic [19:0] addr);
        assert (rsp.err && !rsp.ack) else begin
            errors++;
            $display("unmapped access to 0x%05h was acknowledged instead of failing", addr);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: done, %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------

    task automatic ram_test();
        soc_bus_pkg::bus_rsp_t rsp;
        logic [7:0] idx [32];
        logic [31:0] data;
        logic [3:0] byte_sel;
        for (int k = 0; k < 32; k++) begin
            data = next_random();
            idx[k] = {k[4:0], data[2:0]};
            data = next_random();
            bus_access(1'b0, 1'b1, ram_addr(idx[k]), data, 4'hf, rsp);
            check_ack(rsp, ram_addr(idx[k]));
            shadow[idx[k]] = data;
        end
        // Partial writes over every fourth word.
        for (int k = 0; k < 32; k += 4) begin
            data = next_random();
            byte_sel = (data[3:0] == 4'hf) ? 4'h6 : data[3:0];
            data = next_random();
            bus_access(1'b0, 1'b1, ram_addr(idx[k]), data, byte_sel, rsp);
            check_ack(rsp, ram_addr(idx[k]));
            shadow[idx[k]] = merge_bytes(shadow[idx[k]], data, byte_sel);
        end
        for (int k = 0; k < 32; k++) begin
            bus_access(1'b0, 1'b0, ram_addr(idx[k]), 32'h0, 4'hf, rsp);
            check_ack(rsp, ram_addr(idx[k]));
            check_value("cpu_rsp.dat_r", shadow[idx[k]], rsp.dat_r);
        end
        end_test("ram_readback");
    endtask

    task automatic status_test();
        soc_bus_pkg::bus_rsp_t rsp;
        logic [31:0] data;
        int frames;
        data = next_random();
        frames = 3 + int'(data[3:0]);
        for (int k = 0; k < frames; k++) begin
            @(posedge clk);
            frame_tick <= 1'b1;
            @(posedge clk);
            frame_tick <= 1'b0;
        end
        bus_access(1'b0, 1'b0, frame_addr, 32'h0, 4'hf, rsp);
        check_ack(rsp, frame_addr);
        check_value("cpu_rsp.dat_r", 32'(frames), rsp.dat_r);
        data = next_random();
        bus_access(1'b0, 1'b1, frame_addr, data, 4'hf, rsp);
        check_ack(rsp, frame_addr);
        bus_access(1'b0, 1'b0, frame_addr, 32'h0, 4'hf, rsp);
        check_value("cpu_rsp.dat_r", 32'(frames), rsp.dat_r);
        data = next_random();
        bus_access(1'b0, 1'b1, led_addr, data, 4'hf, rsp);
        check_ack(rsp, led_addr);
        @(negedge clk);
        check_value("leds", {24'h0, data[7:0]}, {24'h0, leds});
        bus_access(1'b0, 1'b0, led_addr, 32'h0, 4'hf, rsp);
        check_value("cpu_rsp.dat_r", {24'h0, data[7:0]}, rsp.dat_r);
        end_test("status_block");
    endtask

    task automatic pad_test();
        soc_bus_pkg::bus_rsp_t rsp;
        logic [31:0] data;
        for (int k = 0; k < 4; k++) begin
            data = next_random();
            @(posedge clk);
            pad_buttons_in <= data[soc_bus_pkg::pad_buttons-1:0];
            repeat (3) @(posedge clk);
            bus_access(1'b0, 1'b0, pad_addr, 32'h0, 4'hf, rsp);
            check_ack(rsp, pad_addr);
            check_value("cpu_rsp.dat_r", 32'(data[soc_bus_pkg::pad_buttons-1:0]), rsp.dat_r);
        end
        end_test("gamepad");
    endtask

    task automatic unmapped_test();
        soc_bus_pkg::bus_rsp_t rsp;
        logic [2:0] bad_regions [5];
        logic [31:0] data;
        logic [19:0] addr;
        bad_regions = '{3'd1, 3'd3, 3'd5, 3'd6, 3'd7};
        for (int k = 0; k < 6; k++) begin
            data = next_random();
            if (k < 5) begin
                addr = {1'b0, bad_regions[k], data[15:2], 2'b00};
            end else begin
                addr = {1'b1, data[18:2], 2'b00};
            end
            bus_access(1'b0, 1'b0, addr, 32'h0, 4'hf, rsp);
            check_err(rsp, addr);
            bus_access(1'b0, 1'b1, addr, data, 4'hf, rsp);
            check_err(rsp, addr);
        end
        end_test("unmapped");
    endtask

    task automatic contention_test();
        soc_bus_pkg::bus_rsp_t cpu_result;
        soc_bus_pkg::bus_rsp_t dma_result;
        logic [7:0] cpu_idx;
        logic [7:0] dma_idx;
        logic [31:0] cpu_data;
        logic [31:0] dma_data;
        // The cpu made the last transfer before this test.
        grant_log.delete();
        grant_log.push_back(1'b0);
        for (int r = 0; r < 16; r++) begin
            cpu_data = next_random();
            dma_data = next_random();
            cpu_idx = {1'b0, r[3:0], cpu_data[2:0]};
            dma_idx = {1'b1, r[3:0], dma_data[2:0]};
            fork
                bus_access(1'b0, 1'b1, ram_addr(cpu_idx), cpu_data, 4'hf, cpu_result);
                bus_access(1'b1, 1'b1, ram_addr(dma_idx), dma_data, 4'hf, dma_result);
            join
            check_ack(cpu_result, ram_addr(cpu_idx));
            check_ack(dma_result, ram_addr(dma_idx));
            shadow[cpu_idx] = cpu_data;
            shadow[dma_idx] = dma_data;
            // The tie winner reads alone, which hands the next tie to the other master.
            if (r[0]) begin
                bus_access(1'b0, 1'b0, ram_addr(cpu_idx), 32'h0, 4'hf, cpu_result);
                check_value("cpu_rsp.dat_r", shadow[cpu_idx], cpu_result.dat_r);
            end else begin
                bus_access(1'b1, 1'b0, ram_addr(dma_idx), 32'h0, 4'hf, dma_result);
                check_value("dma_rsp.dat_r", shadow[dma_idx], dma_result.dat_r);
            end
            fork
                bus_access(1'b0, 1'b0, ram_addr(cpu_idx), 32'h0, 4'hf, cpu_result);
                bus_access(1'b1, 1'b0, ram_addr(dma_idx), 32'h0, 4'hf, dma_result);
            join
            check_value("cpu_rsp.dat_r", shadow[cpu_idx], cpu_result.dat_r);
            check_value("dma_rsp.dat_r", shadow[dma_idx], dma_result.dat_r);
        end
        for (int k = 1; k < grant_log.size(); k++) begin
            assert (grant_log[k] != grant_log[k-1]) else begin
                errors++;
                $display("transfer %0d went to the same master as the one before it", k);
            end
        end
        end_test("contention");
    endtask

    // ----------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------

    initial begin
        int assert_fails;
        reset = 1'b1;
        cpu_req = '0;
        dma_req = '0;
        frame_tick = 1'b0;
        pad_buttons_in = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        ram_test();
        status_test();
        pad_test();
        unmapped_test();
        contention_test();
        assert_fails = i_dut.i_asserts.excl_fails + i_dut.i_asserts.stray_ack_fails
                     + i_dut.i_asserts.dual_rsp_fails + i_dut.i_asserts.reset_rsp_fails;
        $display("tests: %0d, errors: %0d, assertion failures: %0d",
                 tests, errors, assert_fails);
        if (errors + assert_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- soc_bus.f
hdl/soc_bus_pkg.sv
hdl/bus_arbiter.sv
hdl/address_decoder.sv
hdl/cpu_ram.sv
hdl/status_regs.sv
hdl/pad_port.sv
hdl/soc_bus.sv
dv/soc_bus_asserts.sv
dv/soc_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the console bus testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
        --top-module soc_bus_tb -f soc_bus.f -Mdir obj_dir -o soc_bus_sim; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/soc_bus_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
